//--- hdl/udp_tx_pkg.sv
/*
 * Shared definitions for the UDP/IP transmit path:
 * stream word layout, template entry flags, header sizes, engine state width
 */
package udp_tx_pkg;

   // Stream word, three flags above the data bits
   localparam int data_w   = 16;
   localparam int sof_bit  = 16;
   localparam int eof_bit  = 17;
   localparam int occ_bit  = 18;  // Last word only half full
   localparam int stream_w = 19;

   // Template entry, literal word plus six per-line flags
   localparam int hdr_w            = 22;
   localparam int hdr_udp_len_bit  = 16;
   localparam int hdr_ip_len_bit   = 17;
   localparam int hdr_ip_chk_bit   = 18;
   localparam int hdr_last_bit     = 19;
   localparam int hdr_dst_port_bit = 20;
   localparam int hdr_src_port_bit = 21;
   localparam int hdr_len          = 32;  // Up to 64 bytes of header

   // Fixed header sizes added to the payload byte count
   localparam int ip_udp_hdr_bytes = 28;
   localparam int udp_hdr_bytes    = 8;

   // Engine state doubles as the template read index
   localparam int st_w = 5;

   // Port table select from the control word
   localparam int port_sel_w = 2;

endpackage

//--- hdl/tx_fifo.sv
/*
 * Synchronous stream FIFO with valid/ready on both ports
 */
`timescale 1ns/1ps

module tx_fifo #(
   parameter int unsigned DEPTH = 8
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [udp_tx_pkg::stream_w-1:0] wr_data_i,
   input  logic                          wr_valid_i,
   output logic                          wr_ready_o,
   output logic [udp_tx_pkg::stream_w-1:0] rd_data_o,
   output logic                          rd_valid_o,
   input  logic                          rd_ready_i
);
   import udp_tx_pkg::*;

   localparam int ptr_w = $clog2(DEPTH);  // DEPTH is a power of two
   localparam int cnt_w = $clog2(DEPTH + 1);

   logic [stream_w-1:0] mem [DEPTH];
   logic [ptr_w-1:0]    wr_ptr;
   logic [ptr_w-1:0]    rd_ptr;
   logic [cnt_w-1:0]    count;
   logic                do_wr;
   logic                do_rd;

   assign wr_ready_o = (count != cnt_w'(DEPTH));
   assign rd_valid_o = (count != '0);
   assign rd_data_o  = mem[rd_ptr];  // Head word shown directly

   assign do_wr = wr_valid_i & wr_ready_o;
   assign do_rd = rd_valid_o & rd_ready_i;

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data_i;
   end

   // Pointers wrap naturally at DEPTH
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle or pass-through
         endcase
      end
   end

endmodule

//--- hdl/hdr_template.sv
/*
 * Header template store: settings-bus decode, template RAM,
 * checksum seed capture and per-port UDP port table
 */
`timescale 1ns/1ps

module hdr_template #(
   parameter int unsigned SET_BASE = 0
) (
   input  logic                              clk,
   input  logic                              set_stb_i,
   input  logic [7:0]                        set_addr_i,
   input  logic [31:0]                       set_data_i,
   input  logic [udp_tx_pkg::st_w-1:0]       rd_idx_i,
   input  logic [udp_tx_pkg::port_sel_w-1:0] port_sel_i,
   output logic [udp_tx_pkg::hdr_w-1:0]      hdr_word_o,
   output logic [udp_tx_pkg::data_w-1:0]     chk_seed_o,
   output logic [udp_tx_pkg::data_w-1:0]     src_port_o,
   output logic [udp_tx_pkg::data_w-1:0]     dst_port_o
);
   import udp_tx_pkg::*;

   // Template at base+0..31, port table right after it
   localparam logic [7:0] tmpl_base = 8'(SET_BASE);
   localparam logic [7:0] port_base = 8'(SET_BASE + hdr_len);

   logic [hdr_w-1:0]    tmpl_ram [hdr_len];
   logic [2*data_w-1:0] port_tab [2**port_sel_w];  // {src, dst}
   logic                tmpl_wr;
   logic                port_wr;

   assign tmpl_wr = set_stb_i & (set_addr_i[7:st_w] == tmpl_base[7:st_w]);
   assign port_wr = set_stb_i & (set_addr_i[7:port_sel_w] == port_base[7:port_sel_w]);

   always_ff @(posedge clk)
   begin
      if (tmpl_wr)
      begin
         tmpl_ram[set_addr_i[st_w-1:0]] <= set_data_i[hdr_w-1:0];
         // Host preloads the static part of the IP checksum on this line
         if (set_data_i[hdr_ip_chk_bit])
            chk_seed_o <= set_data_i[data_w-1:0];
      end
      if (port_wr)
         port_tab[set_addr_i[port_sel_w-1:0]] <= set_data_i;
   end

   // Ports of the selected entry, one cycle behind port_sel_i
   always_ff @(posedge clk)
   begin
      src_port_o <= port_tab[port_sel_i][2*data_w-1:data_w];
      dst_port_o <= port_tab[port_sel_i][data_w-1:0];
   end

   assign hdr_word_o = tmpl_ram[rd_idx_i];  // Distributed RAM read

endmodule

//--- hdl/prot_eng_tx.sv
/*
 * Transmit protocol engine: control and count word FSM, header line
 * substitution, length and IP checksum arithmetic, output framing
 */
`timescale 1ns/1ps

module prot_eng_tx (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [udp_tx_pkg::stream_w-1:0]   in_data_i,
   input  logic                              in_valid_i,
   output logic                              in_ready_o,
   output logic [udp_tx_pkg::stream_w-1:0]   out_data_o,
   output logic                              out_valid_o,
   input  logic                              out_ready_i,
   output logic [udp_tx_pkg::st_w-1:0]       rd_idx_o,
   input  logic [udp_tx_pkg::hdr_w-1:0]      hdr_word_i,
   input  logic [udp_tx_pkg::data_w-1:0]     chk_seed_i,
   output logic [udp_tx_pkg::port_sel_w-1:0] port_sel_o,
   input  logic [udp_tx_pkg::data_w-1:0]     src_port_i,
   input  logic [udp_tx_pkg::data_w-1:0]     dst_port_i
);
   import udp_tx_pkg::*;

   localparam logic [st_w-1:0] st_ctrl    = st_w'(0);
   localparam logic [st_w-1:0] st_count   = st_w'(1);
   localparam logic [st_w-1:0] st_hdr0    = st_w'(2);   // First header line
   localparam logic [st_w-1:0] st_align   = st_w'(30);
   localparam logic [st_w-1:0] st_payload = st_w'(31);

   logic [st_w-1:0]   state;
   logic              fast_path;
   logic              sof;
   logic [data_w-1:0] length;
   logic [data_w-1:0] ip_length;
   logic [data_w-1:0] udp_length;
   logic [data_w:0]   chk_sum;
   logic [data_w-1:0] chk_fold;
   logic [data_w-1:0] chk_reg;
   logic [data_w-1:0] out_word;
   logic              do_payload;
   logic              no_output;
   logic              advance;

   assign do_payload = (state == st_payload);
   // Control, count and alignment words are swallowed
   assign no_output  = (state == st_ctrl) | (state == st_count) | (state == st_align);

   // Header states emit while the first payload word waits at the input
   assign in_ready_o  = out_ready_i & (do_payload | no_output);
   assign out_valid_o = in_valid_i & ~no_output;
   assign advance     = in_valid_i & out_ready_i;

   assign rd_idx_o = state;

   assign ip_length  = length + data_w'(ip_udp_hdr_bytes);
   assign udp_length = length + data_w'(udp_hdr_bytes);

   // Ones'-complement add with end-around carry
   assign chk_sum  = {1'b0, chk_seed_i} + {1'b0, ip_length};
   assign chk_fold = chk_sum[data_w-1:0] + {{(data_w-1){1'b0}}, chk_sum[data_w]};

   always_ff @(posedge clk)
   begin
      chk_reg <= chk_fold;  // Valid one cycle after the count word
   end

   always_ff @(posedge clk)
   begin
      if (advance && (state == st_count))
         length <= in_data_i[data_w-1:0];  // Payload byte count
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= st_ctrl;
         fast_path  <= 1'b0;
         port_sel_o <= '0;
         sof        <= 1'b0;
      end
      else if (advance)
      begin
         case (state)
            st_ctrl:
            begin
               fast_path  <= in_data_i[0];
               port_sel_o <= in_data_i[port_sel_w:1];
               state      <= st_count;
            end
            st_count:
            begin
               sof <= 1'b1;  // Marks the next emitted word
               if (fast_path)
                  state <= st_hdr0;
               else
                  state <= st_align;
            end
            st_align:
               state <= st_payload;  // Alignment word dropped
            st_payload:
            begin
               sof <= 1'b0;
               if (in_data_i[eof_bit])
                  state <= st_ctrl;
            end
            default:
            begin
               // Header line emitted
               sof <= 1'b0;
               if (hdr_word_i[hdr_last_bit])
                  state <= st_payload;
               else
                  state <= state + 1'b1;
            end
         endcase
      end
   end

   // Line flags in priority order
   always_comb
   begin
      if (do_payload)
         out_word = in_data_i[data_w-1:0];
      else if (hdr_word_i[hdr_ip_chk_bit])
         out_word = ~chk_reg;
      else if (hdr_word_i[hdr_ip_len_bit])
         out_word = ip_length;
      else if (hdr_word_i[hdr_udp_len_bit])
         out_word = udp_length;
      else if (hdr_word_i[hdr_src_port_bit])
         out_word = src_port_i;
      else if (hdr_word_i[hdr_dst_port_bit])
         out_word = dst_port_i;
      else
         out_word = hdr_word_i[data_w-1:0];  // Literal line
   end

   // EOF and OCC belong to payload words only, never to header lines
   always_comb
   begin
      out_data_o                = '0;
      out_data_o[data_w-1:0]    = out_word;
      out_data_o[sof_bit]       = sof;
      out_data_o[eof_bit]       = do_payload & in_data_i[eof_bit];
      out_data_o[occ_bit]       = do_payload & in_data_i[occ_bit];
   end

endmodule

//--- hdl/udp_tx_top.sv
/*
 * UDP/IP transmit top level: input FIFO, header template store, engine
 */
`timescale 1ns/1ps

module udp_tx_top #(
   parameter int unsigned SET_BASE   = 0,  // Multiple of 64
   parameter int unsigned FIFO_DEPTH = 8
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            set_stb_i,
   input  logic [7:0]                      set_addr_i,
   input  logic [31:0]                     set_data_i,
   input  logic [udp_tx_pkg::stream_w-1:0] in_data_i,
   input  logic                            in_valid_i,
   output logic                            in_ready_o,
   output logic [udp_tx_pkg::stream_w-1:0] out_data_o,
   output logic                            out_valid_o,
   input  logic                            out_ready_i
);
   import udp_tx_pkg::*;

   logic [stream_w-1:0]   fifo_data;
   logic                  fifo_valid;
   logic                  eng_ready;
   logic [st_w-1:0]       rd_idx;
   logic [hdr_w-1:0]      hdr_word;
   logic [data_w-1:0]     chk_seed;
   logic [data_w-1:0]     src_port;
   logic [data_w-1:0]     dst_port;
   logic [port_sel_w-1:0] port_sel;

   tx_fifo #(
      .DEPTH(FIFO_DEPTH)
   ) u_tx_fifo (
      .clk       (clk),
      .reset     (reset),
      .wr_data_i (in_data_i),
      .wr_valid_i(in_valid_i),
      .wr_ready_o(in_ready_o),
      .rd_data_o (fifo_data),
      .rd_valid_o(fifo_valid),
      .rd_ready_i(eng_ready)
   );

   hdr_template #(
      .SET_BASE(SET_BASE)
   ) u_hdr_template (
      .clk       (clk),
      .set_stb_i (set_stb_i),
      .set_addr_i(set_addr_i),
      .set_data_i(set_data_i),
      .rd_idx_i  (rd_idx),
      .port_sel_i(port_sel),
      .hdr_word_o(hdr_word),
      .chk_seed_o(chk_seed),
      .src_port_o(src_port),
      .dst_port_o(dst_port)
   );

   prot_eng_tx u_prot_eng_tx (
      .clk        (clk),
      .reset      (reset),
      .in_data_i  (fifo_data),
      .in_valid_i (fifo_valid),
      .in_ready_o (eng_ready),
      .out_data_o (out_data_o),
      .out_valid_o(out_valid_o),
      .out_ready_i(out_ready_i),
      .rd_idx_o   (rd_idx),
      .hdr_word_i (hdr_word),
      .chk_seed_i (chk_seed),
      .port_sel_o (port_sel),
      .src_port_i (src_port),
      .dst_port_i (dst_port)
   );

endmodule

//--- tests/tb_clk_gen.sv
/*
 * Testbench clock and synchronous reset generator
 */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_NS      = 5,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic reset_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #HALF_NS clk_o = ~clk_o;
   end

   // Released on a falling edge, clear of the sampling edge
   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

//--- tests/tb_udp_tx.sv
/*
 * Testbench for the UDP/IP transmit top level with packet stimulus,
 * reference model and expected word queue, output checks and watchdog
 */
`timescale 1ns/1ps

module tb_udp_tx;
   import udp_tx_pkg::*;

   localparam int set_base   = 64;
   localparam int fifo_depth = 8;

   // Template line flags
   localparam logic [hdr_w-1:0] f_udp_len = 22'h010000;
   localparam logic [hdr_w-1:0] f_ip_len  = 22'h020000;
   localparam logic [hdr_w-1:0] f_ip_chk  = 22'h040000;
   localparam logic [hdr_w-1:0] f_last    = 22'h080000;
   localparam logic [hdr_w-1:0] f_dst     = 22'h100000;
   localparam logic [hdr_w-1:0] f_src     = 22'h200000;

   logic                clk;
   logic                reset;
   logic                set_stb;
   logic [7:0]          set_addr;
   logic [31:0]         set_data;
   logic [stream_w-1:0] in_data;
   logic                in_valid;
   logic                in_ready;
   logic [stream_w-1:0] out_data;
   logic                out_valid;
   logic                out_ready;

   logic [hdr_w-1:0]    tmpl [hdr_len];  // Copy of what the host wrote
   logic [31:0]         port_tab [4];    // {src, dst}
   logic [15:0]         seed_val;
   logic [stream_w-1:0] exp_q [$];
   logic [stream_w-1:0] exp_w;
   bit                  bp_on;
   bit                  gaps_on;
   int                  seed = 88;
   int                  errors;
   int                  checked;
   int                  test_count;
   int                  work_units;
   int                  err_mark;
   int                  chk_mark;

   tb_clk_gen #(
      .HALF_NS     (5),
      .RESET_CYCLES(10)
   ) u_clk_gen (
      .clk_o  (clk),
      .reset_o(reset)
   );

   udp_tx_top #(
      .SET_BASE  (set_base),
      .FIFO_DEPTH(fifo_depth)
   ) u_udp_tx_top (
      .clk        (clk),
      .reset      (reset),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .in_data_i  (in_data),
      .in_valid_i (in_valid),
      .in_ready_o (in_ready),
      .out_data_o (out_data),
      .out_valid_o(out_valid),
      .out_ready_i(out_ready)
   );

   function automatic logic [stream_w-1:0] stream_word(input logic sof, input logic eof,
                                                       input logic occ, input logic [15:0] d);
      return {occ, eof, sof, d};
   endfunction

   function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
      logic [16:0] s;
      s = {1'b0, a} + {1'b0, b};
      return s[15:0] + {15'd0, s[16]};  // End-around carry
   endfunction

   // Checksum wins over IP length, then UDP length, source and destination port
   function automatic logic [15:0] line_value(input logic [hdr_w-1:0] line,
                                              input logic [15:0] ip_len,
                                              input logic [15:0] udp_len,
                                              input logic [1:0] port);
      if (line[hdr_ip_chk_bit])
         return ~ones_add(seed_val, ip_len);
      else if (line[hdr_ip_len_bit])
         return ip_len;
      else if (line[hdr_udp_len_bit])
         return udp_len;
      else if (line[hdr_src_port_bit])
         return port_tab[port][31:16];
      else if (line[hdr_dst_port_bit])
         return port_tab[port][15:0];
      return line[15:0];
   endfunction

   function automatic int rand_int(input int lo, input int hi);
      return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
   endfunction

   task automatic set_write(input int addr, input logic [31:0] data);
      @(negedge clk);
      set_stb  = 1'b1;
      set_addr = 8'(set_base + addr);
      set_data = data;
      @(negedge clk);
      set_stb  = 1'b0;
      work_units++;
   endtask

   task automatic write_line(input int idx, input logic [hdr_w-1:0] v);
      set_write(idx, {10'd0, v});
      tmpl[idx] = v;
      if (v[hdr_ip_chk_bit])
         seed_val = v[15:0];  // Static part of the IP checksum
   endtask

   task automatic write_port(input logic [1:0] sel, input logic [15:0] src,
                             input logic [15:0] dst);
      set_write(hdr_len + int'(sel), {src, dst});
      port_tab[sel] = {src, dst};
   endtask

   task automatic send_word(input logic [stream_w-1:0] w);
      bit done;
      done = 1'b0;
      work_units++;
      while (!done)
      begin
         @(negedge clk);
         if (gaps_on && (($random(seed) & 3) == 0))
            in_valid = 1'b0;  // Source idles this cycle
         else
         begin
            in_data  = w;
            in_valid = 1'b1;
            done     = in_ready;  // Transfers on the next rising edge
         end
      end
   endtask

   task automatic push_exp(input logic [stream_w-1:0] w);
      exp_q.push_back(w);
      work_units++;
   endtask

   task automatic send_packet(input bit fast, input logic [1:0] port, input int count);
      logic [15:0] pay [$];
      logic [15:0] ip_len;
      logic [15:0] udp_len;
      int          nwords;
      int          idx;
      int          k;
      bit          first;
      bit          last;
      bit          done;

      ip_len  = 16'(count + 28);
      udp_len = 16'(count + 8);
      nwords  = (count + 1) / 2;
      for (k = 0; k < nwords; k++)
         pay.push_back(16'($random(seed)));

      first = 1'b1;
      if (fast)
      begin
         idx  = 2;
         done = 1'b0;
         while (!done)
         begin
            push_exp(stream_word(first, 1'b0, 1'b0,
                                 line_value(tmpl[idx], ip_len, udp_len, port)));
            first = 1'b0;
            done  = tmpl[idx][hdr_last_bit] || (idx == 29);
            idx++;
         end
      end
      for (k = 0; k < nwords; k++)
      begin
         last = (k == nwords - 1);
         push_exp(stream_word(first, last, last && (count % 2 == 1), pay[k]));
         first = 1'b0;
      end

      send_word(stream_word(1'b1, 1'b0, 1'b0, {13'd0, port, fast}));
      send_word(stream_word(1'b0, 1'b0, 1'b0, 16'(count)));
      if (!fast)
         send_word(stream_word(1'b0, 1'b0, 1'b0, 16'hdead));  // Alignment filler
      for (k = 0; k < nwords; k++)
      begin
         last = (k == nwords - 1);
         send_word(stream_word(1'b0, last, last && (count % 2 == 1), pay[k]));
      end
   endtask

   task automatic drain();
      @(negedge clk);
      in_valid = 1'b0;
      while (exp_q.size() != 0)
         @(negedge clk);
   endtask

   task automatic end_test(input string name);
      drain();
      test_count++;
      $display("Test %0d (%s) finished: %0d words checked, %0d errors",
               test_count, name, checked - chk_mark, errors - err_mark);
      err_mark = errors;
      chk_mark = checked;
   endtask

   // IPv4 plus UDP header on lines 2 to 15
   task automatic load_full_template();
      write_line(2, 22'h004500);
      write_line(3, f_ip_len);
      write_line(4, 22'h001c46);
      write_line(5, 22'h004000);
      write_line(6, 22'h004011);
      write_line(7, f_ip_chk | 22'h001b2c);
      write_line(8, 22'h00c0a8);
      write_line(9, 22'h000001);
      write_line(10, 22'h00c0a8);
      write_line(11, 22'h000002);
      write_line(12, f_src);
      write_line(13, f_dst);
      write_line(14, f_udp_len);
      write_line(15, f_last);  // UDP checksum unused
   endtask

   // Compares each accepted output word with the head of the queue
   always @(posedge clk)
   begin
      if (!reset && out_valid && out_ready)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("Output word %h at %0t arrived when no word was expected",
                     out_data, $time);
            errors++;
         end
         if (exp_q.size() != 0)
         begin
            exp_w = exp_q.pop_front();
            checked++;
            assert (out_data == exp_w)
            else
            begin
               $display("CHECK FAILED at %0t: output word %h, expected %h",
                        $time, out_data, exp_w);
               errors++;
            end
         end
      end
   end

   initial
   begin
      out_ready = 1'b0;
      forever
      begin
         @(negedge clk);
         if (bp_on)
            out_ready = (($random(seed) & 3) != 0);  // Sink stalls now and then
         else
            out_ready = 1'b1;
      end
   end

   // Budget grows with every bus write, input word and expected output word
   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 20 * (work_units + 10))
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: no finish within %0d cycles, the output stream stalled", cycles - 1);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      int          k;
      logic [15:0] chk_seeds [4];

      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      in_data  = '0;
      in_valid = 1'b0;
      chk_seeds[0] = 16'hffff;
      chk_seeds[1] = 16'hffe0;
      chk_seeds[2] = 16'h8001;
      chk_seeds[3] = 16'($random(seed));
      @(negedge reset);

      for (k = 0; k < hdr_len; k++)
         write_line(k, '0);
      for (k = 0; k < 4; k++)
         write_port(2'(k), 16'($random(seed)), 16'($random(seed)));

      for (k = 0; k < 3; k++)
         send_packet(1'b0, 2'(rand_int(0, 3)), rand_int(1, 40));
      end_test("slow path");

      write_line(2, 22'h00aa55);
      write_line(3, 22'h001234);
      write_line(4, 22'h00beef);
      write_line(5, f_last | 22'h000f0f);
      for (k = 0; k < 3; k++)
         send_packet(1'b1, 2'(rand_int(0, 3)), rand_int(1, 40));
      end_test("fast path literal lines");

      load_full_template();
      for (k = 0; k < 5; k++)
         send_packet(1'b1, 2'(rand_int(0, 3)), rand_int(1, 64));
      end_test("length fields");

      for (k = 0; k < 4; k++)
      begin
         write_line(7, f_ip_chk | {6'd0, chk_seeds[k]});
         send_packet(1'b1, 2'(rand_int(0, 3)), rand_int(1, 64));
         send_packet(1'b1, 2'(rand_int(0, 3)), rand_int(1, 64));
         drain();  // Seed must not change under a packet still in flight
      end
      end_test("checksum");

      for (k = 0; k < 4; k++)
         send_packet(1'b1, 2'(k), rand_int(1, 64));
      end_test("port table");

      bp_on   = 1'b1;
      gaps_on = 1'b1;
      for (k = 0; k < 8; k++)
         send_packet(rand_int(0, 1) == 1, 2'(rand_int(0, 3)), rand_int(1, 30));
      end_test("back-pressure");
      bp_on   = 1'b0;
      gaps_on = 1'b0;

      repeat (20) @(negedge clk);  // Catch any trailing extra word
      $display("Tests run: %0d, words checked: %0d, errors: %0d", test_count, checked, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- src.f
hdl/udp_tx_pkg.sv
hdl/tx_fifo.sv
hdl/hdr_template.sv
hdl/prot_eng_tx.sv
hdl/udp_tx_top.sv
tests/tb_clk_gen.sv
tests/tb_udp_tx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UDP transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_udp_tx -f src.f

out=$(./obj_dir/Vtb_udp_tx)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
